// File: rtl/dram_front_settings.svh
`ifndef DRAM_FRONT_SETTINGS_SVH
`define DRAM_FRONT_SETTINGS_SVH

//////////////////////////////////////////////////
// dram address field widths
//////////////////////////////////////////////////

// bank address
`define DF_BA_W 2
// bank group
`define DF_BG_W 2
// row
`define DF_RO_W 8
// column
`define DF_CO_W 5
// byte offset within one dram word
`define DF_BO_W 3

//////////////////////////////////////////////////
// machine shape
//////////////////////////////////////////////////

// source coordinate carried by the cache dma request
`define DF_CORD_W 8
// low cord bits select the ruche lane, not the vcache
`define DF_LG_RUCHE 1
`define DF_LG_VC_PER_LINK 2
// vcaches sharing one dram channel
`define DF_VC_PER_CHANNEL 2
`define DF_NUM_CHANNELS 8

`endif

// File: rtl/dram_geom_pkg.sv
`include "dram_front_settings.svh"

package dram_geom_pkg;

  // one vector type per address field
  typedef logic [`DF_BA_W-1:0] ba_t;
  typedef logic [`DF_BG_W-1:0] bg_t;
  typedef logic [`DF_RO_W-1:0] ro_t;
  typedef logic [`DF_CO_W-1:0] co_t;
  typedef logic [`DF_BO_W-1:0] bo_t;

  // address of one cache's region inside a channel
  typedef logic [`DF_BA_W+`DF_BG_W+`DF_RO_W+`DF_CO_W+`DF_BO_W-1:0] bank_addr_t;

  // field order as the cache dma emits it
  typedef struct packed {
    ba_t ba;
    bg_t bg;
    ro_t ro;
    co_t co;
    bo_t bo;
  } cache_ch_addr_s;

  // field order the dram model maps with
  typedef struct packed {
    ro_t ro;
    bg_t bg;
    ba_t ba;
    co_t co;
    bo_t bo;
  } sim_ch_addr_s;

  typedef logic [$clog2(`DF_NUM_CHANNELS)-1:0] channel_t;
  typedef logic [$clog2(`DF_VC_PER_CHANNEL)-1:0] slot_t;

  // slot on top of the bank address
  typedef logic [$bits(slot_t)+$bits(bank_addr_t)-1:0] ch_addr_t;

endpackage

// File: rtl/vcache_dma_pkg.sv
`include "dram_front_settings.svh"

package vcache_dma_pkg;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // horizontal side in the upper bit, vertical side in the lower
  typedef logic [1:0] side_t;

  typedef logic [`DF_CORD_W-1:0] cord_t;

  // one cache dma request as seen at the memory edge
  typedef struct packed {
    logic                      write_not_read;
    side_t                     side;
    cord_t                     src_cord;
    dram_geom_pkg::bank_addr_t addr;
  } dma_req_s;

  //////////////////////////////////////////////////
  // dram side
  //////////////////////////////////////////////////

  // request handed to the dram model
  typedef struct packed {
    logic                    write_not_read;
    dram_geom_pkg::channel_t channel;
    dram_geom_pkg::ch_addr_t ch_addr;
  } dram_req_s;

endpackage

// File: rtl/dma_channel_map.sv
`timescale 1ns/1ps

`include "dram_front_settings.svh"

module dma_channel_map (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_v_i,
  input  vcache_dma_pkg::side_t   side_i,
  input  vcache_dma_pkg::cord_t   src_cord_i,
  output logic                    v_o,
  output dram_geom_pkg::channel_t channel_o,
  output dram_geom_pkg::slot_t    slot_o
);

  import dram_geom_pkg::*;

  localparam int gid_w = $bits(side_i) + `DF_LG_VC_PER_LINK;

  logic [`DF_LG_VC_PER_LINK-1:0] link_vc_id;
  logic [gid_w-1:0]              global_id;
  channel_t                      channel_n;
  slot_t                         slot_n;

  logic     v_r;
  channel_t channel_r;
  slot_t    slot_r;

  // vcache index along its link, above the ruche lane bits
  assign link_vc_id = src_cord_i[`DF_LG_RUCHE +: `DF_LG_VC_PER_LINK];

  // sides pick which quarter of the machine
  assign global_id = {side_i, link_vc_id};

  // neighbouring caches share a channel
  assign channel_n = channel_t'(global_id / `DF_VC_PER_CHANNEL);
  assign slot_n    = slot_t'(global_id % `DF_VC_PER_CHANNEL);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= req_v_i;
    end
  end

  // mapping only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      channel_r <= channel_n;
      slot_r    <= slot_n;
    end
  end

  assign v_o       = v_r;
  assign channel_o = channel_r;
  assign slot_o    = slot_r;

endmodule

// File: rtl/dram_addr_hash.sv
`timescale 1ns/1ps

module dram_addr_hash (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  dram_geom_pkg::bank_addr_t     req_addr_i,
  output dram_geom_pkg::sim_ch_addr_s   hashed_o,
  input  logic                          read_done_v_i,
  input  dram_geom_pkg::sim_ch_addr_s   read_done_addr_i,
  output logic                          resp_v_o,
  output dram_geom_pkg::cache_ch_addr_s resp_addr_o
);

  import dram_geom_pkg::*;

  cache_ch_addr_s req_fields;
  sim_ch_addr_s   hashed_n;
  sim_ch_addr_s   hashed_r;

  cache_ch_addr_s resp_addr_n;
  cache_ch_addr_s resp_addr_r;
  logic           resp_v_r;

  //////////////////////////////////////////////////
  // forward path, cache order to dram order
  //////////////////////////////////////////////////

  // flat bank address viewed as ba-bg-ro-co-bo
  assign req_fields = req_addr_i;

  always_comb begin
    hashed_n.ro = req_fields.ro;
    hashed_n.bg = req_fields.bg;
    hashed_n.ba = req_fields.ba;
    hashed_n.co = req_fields.co;
    hashed_n.bo = req_fields.bo;
  end

  // stage one, lines up with the channel mapper
  always_ff @(posedge clk_i) begin
    hashed_r <= hashed_n;
  end

  assign hashed_o = hashed_r;

  //////////////////////////////////////////////////
  // return path, dram order back to cache order
  //////////////////////////////////////////////////

  always_comb begin
    resp_addr_n.ba = read_done_addr_i.ba;
    resp_addr_n.bg = read_done_addr_i.bg;
    resp_addr_n.ro = read_done_addr_i.ro;
    resp_addr_n.co = read_done_addr_i.co;
    resp_addr_n.bo = read_done_addr_i.bo;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= read_done_v_i;
    end
  end

  // hold last address between read-dones
  always_ff @(posedge clk_i) begin
    if (read_done_v_i) begin
      resp_addr_r <= resp_addr_n;
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_addr_o = resp_addr_r;

endmodule

// File: rtl/dram_req_merge.sv
`timescale 1ns/1ps

module dram_req_merge (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        v_i,
  input  logic                        write_not_read_i,
  input  dram_geom_pkg::channel_t     channel_i,
  input  dram_geom_pkg::slot_t        slot_i,
  input  dram_geom_pkg::sim_ch_addr_s hashed_i,
  output logic                        dram_v_o,
  output vcache_dma_pkg::dram_req_s   dram_req_o
);

  import dram_geom_pkg::*;
  import vcache_dma_pkg::*;

  logic       wnr_r;
  bank_addr_t hashed_flat;
  dram_req_s  dram_req_n;
  dram_req_s  dram_req_r;
  logic       dram_v_r;

  // write flag arrives with the raw request, one stage early
  always_ff @(posedge clk_i) begin
    wnr_r <= write_not_read_i;
  end

  // dram model takes the hashed fields as one vector
  assign hashed_flat = hashed_i;

  always_comb begin
    dram_req_n.write_not_read = wnr_r;
    dram_req_n.channel        = channel_i;
    // slot selects the cache's half of the channel
    dram_req_n.ch_addr        = {slot_i, hashed_flat};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dram_v_r <= 1'b0;
    end else begin
      dram_v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      dram_req_r <= dram_req_n;
    end
  end

  assign dram_v_o   = dram_v_r;
  assign dram_req_o = dram_req_r;

endmodule

// File: rtl/manycore_dram_front.sv
`timescale 1ns/1ps

module manycore_dram_front (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          dma_req_v_i,
  input  vcache_dma_pkg::dma_req_s      dma_req_i,
  input  logic                          read_done_v_i,
  input  dram_geom_pkg::sim_ch_addr_s   read_done_addr_i,
  output logic                          dram_v_o,
  output vcache_dma_pkg::dram_req_s     dram_req_o,
  output logic                          resp_v_o,
  output dram_geom_pkg::cache_ch_addr_s resp_addr_o
);

  import dram_geom_pkg::*;

  // stage one results
  logic         map_v;
  channel_t     map_channel;
  slot_t        map_slot;
  sim_ch_addr_s hashed;

  //////////////////////////////////////////////////
  // stage one, mapper and hasher side by side
  //////////////////////////////////////////////////

  dma_channel_map u_channel_map (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (dma_req_v_i),
    .side_i     (dma_req_i.side),
    .src_cord_i (dma_req_i.src_cord),
    .v_o        (map_v),
    .channel_o  (map_channel),
    .slot_o     (map_slot)
  );

  // also owns the read-done return path
  dram_addr_hash u_addr_hash (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_addr_i       (dma_req_i.addr),
    .hashed_o         (hashed),
    .read_done_v_i    (read_done_v_i),
    .read_done_addr_i (read_done_addr_i),
    .resp_v_o         (resp_v_o),
    .resp_addr_o      (resp_addr_o)
  );

  //////////////////////////////////////////////////
  // stage two, request to the dram model
  //////////////////////////////////////////////////

  dram_req_merge u_req_merge (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .v_i              (map_v),
    .write_not_read_i (dma_req_i.write_not_read),
    .channel_i        (map_channel),
    .slot_i           (map_slot),
    .hashed_i         (hashed),
    .dram_v_o         (dram_v_o),
    .dram_req_o       (dram_req_o)
  );

endmodule

// File: tb/tb_manycore_dram_front.sv
`timescale 1ns/1ps

module tb_manycore_dram_front;

  import dram_geom_pkg::*;
  import vcache_dma_pkg::*;

  localparam int max_vec = 256;

  typedef enum logic [1:0] {
    kind_idle,
    kind_req,
    kind_rd
  } vec_kind_e;

  // expected request output for one issue cycle
  typedef struct packed {
    logic     v;
    logic     wnr;
    channel_t channel;
    ch_addr_t ch_addr;
  } req_exp_s;

  // expected read-done response for one issue cycle
  typedef struct packed {
    logic           v;
    cache_ch_addr_s addr;
  } rd_exp_s;

  logic           clk_i;
  logic           rst_n_i;
  logic           dma_req_v_i;
  dma_req_s       dma_req_i;
  logic           read_done_v_i;
  sim_ch_addr_s   read_done_addr_i;
  logic           dram_v_o;
  dram_req_s      dram_req_o;
  logic           resp_v_o;
  cache_ch_addr_s resp_addr_o;

  vec_kind_e    kinds [max_vec];
  dma_req_s     req_in [max_vec];
  req_exp_s     req_exp [max_vec];
  sim_ch_addr_s rd_in [max_vec];
  rd_exp_s      rd_exp [max_vec];
  int           num_vec;

  // one entry per driven cycle including idle ones
  req_exp_s req_q [$];
  rd_exp_s  rd_q [$];

  int   err_cnt = 0;
  int   check_cnt = 0;
  int   cycle_cnt = 0;
  int   cycle_limit = 20;
  logic load_ok;

  manycore_dram_front UUT (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dma_req_v_i      (dma_req_v_i),
    .dma_req_i        (dma_req_i),
    .read_done_v_i    (read_done_v_i),
    .read_done_addr_i (read_done_addr_i),
    .dram_v_o         (dram_v_o),
    .dram_req_o       (dram_req_o),
    .resp_v_o         (resp_v_o),
    .resp_addr_o      (resp_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // vector file
  //////////////////////////////////////////////////

  task automatic load_vectors(output logic ok);
    int               fd;
    int               code;
    string            kind_str;
    logic [8*160-1:0] rest;
    logic [31:0]      f [0:6];
    num_vec = 0;
    ok = 1'b0;
    fd = $fopen("tb/dram_front_input.txt", "r");
    if (fd != 0) begin
      code = $fscanf(fd, "%s", kind_str);
      while (code == 1 && num_vec < max_vec) begin
        if (kind_str == "#") begin
          code = $fgets(rest, fd);
        end else begin
          kinds[num_vec] = kind_idle;
          req_in[num_vec] = '0;
          req_exp[num_vec] = '0;
          rd_in[num_vec] = '0;
          rd_exp[num_vec] = '0;
          if (kind_str == "req") begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                           f[6]);
            kinds[num_vec] = kind_req;
            req_in[num_vec].write_not_read = f[0][0];
            req_in[num_vec].side = side_t'(f[1]);
            req_in[num_vec].src_cord = cord_t'(f[2]);
            req_in[num_vec].addr = bank_addr_t'(f[3]);
            req_exp[num_vec].v = 1'b1;
            req_exp[num_vec].wnr = f[4][0];
            req_exp[num_vec].channel = channel_t'(f[5]);
            req_exp[num_vec].ch_addr = ch_addr_t'(f[6]);
          end else if (kind_str == "rd") begin
            code = $fscanf(fd, "%h %h", f[0], f[1]);
            kinds[num_vec] = kind_rd;
            rd_in[num_vec] = sim_ch_addr_s'(bank_addr_t'(f[0]));
            rd_exp[num_vec].v = 1'b1;
            rd_exp[num_vec].addr = cache_ch_addr_s'(bank_addr_t'(f[1]));
          end else if (kind_str != "idle") begin
            err_cnt++;
            $display("unknown vector kind %s in the stimulus file", kind_str);
          end
          num_vec++;
        end
        code = $fscanf(fd, "%s", kind_str);
      end
      $fclose(fd);
      ok = (num_vec > 0);
    end
    cycle_limit = num_vec + 20;
  endtask

  //////////////////////////////////////////////////
  // per-cycle drive and compare
  //////////////////////////////////////////////////

  // request results trail by two cycles, read-dones by one
  task automatic check_outputs();
    req_exp_s req_e;
    rd_exp_s  rd_e;
    if (req_q.size() == 2) begin
      req_e = req_q.pop_front();
      check_value("dram_v_o", 32'(dram_v_o), 32'(req_e.v));
      if (req_e.v) begin
        check_value("dram write flag", 32'(dram_req_o.write_not_read), 32'(req_e.wnr));
        check_value("dram channel", 32'(dram_req_o.channel), 32'(req_e.channel));
        check_value("dram ch_addr", 32'(dram_req_o.ch_addr), 32'(req_e.ch_addr));
      end
    end
    if (rd_q.size() == 1) begin
      rd_e = rd_q.pop_front();
      check_value("resp_v_o", 32'(resp_v_o), 32'(rd_e.v));
      if (rd_e.v) begin
        check_value("resp_addr_o", 32'(resp_addr_o), 32'(rd_e.addr));
      end
    end
  endtask

  task automatic drive_vector(input int idx);
    req_exp_s req_e;
    rd_exp_s  rd_e;
    req_e = '0;
    rd_e = '0;
    dma_req_v_i = 1'b0;
    dma_req_i = '0;
    read_done_v_i = 1'b0;
    read_done_addr_i = '0;
    if (idx < num_vec) begin
      req_e = req_exp[idx];
      rd_e = rd_exp[idx];
      dma_req_v_i = (kinds[idx] == kind_req);
      dma_req_i = req_in[idx];
      read_done_v_i = (kinds[idx] == kind_rd);
      read_done_addr_i = rd_in[idx];
    end
    req_q.push_back(req_e);
    rd_q.push_back(rd_e);
  endtask

  task automatic run_vectors();
    req_exp_s reset_e;
    reset_e = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_value("dram_v_o after reset", 32'(dram_v_o), 32'd0);
    check_value("resp_v_o after reset", 32'(resp_v_o), 32'd0);
    // the last cycle under reset expects no request
    req_q.push_back(reset_e);
    // two extra cycles drain the pipeline
    for (int i = 0; i < num_vec + 2; i++) begin
      check_outputs();
      drive_vector(i);
      @(negedge clk_i);
    end
  endtask

  initial begin
    rst_n_i = 1'b0;
    // valids pending under reset must not reach the outputs
    dma_req_v_i = 1'b1;
    dma_req_i = '0;
    read_done_v_i = 1'b1;
    read_done_addr_i = '0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("stimulus file tb/dram_front_input.txt is missing or holds no vectors");
      $display("Simulation FAILED");
      $finish;
    end else begin
      run_vectors();
      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// File: tb/dram_front_input.txt
# req wnr side cord addr exp_wnr exp_channel exp_ch_addr (all hex, one line per cycle)
# rd sim_addr exp_cache_addr, idle has no fields
idle
idle
idle
req 0 0 00 00000 0 0 000000
idle
idle
idle
req 0 0 02 41234 0 0 112134
idle
idle
idle
req 1 1 04 1abcd 1 3 0ab4cd
idle
idle
req 0 2 06 b5a7f 0 5 15ae7f
req 1 3 07 cff01 1 7 1ff301
req 0 3 f9 f80ff 0 6 080fff
req 1 1 13 63c58 1 2 13c958
req 0 2 2c 901e0 0 5 0016e0
idle
idle
rd 12345 c1245
idle
idle
req 1 0 05 27712 1 1 077812
rd abcde 3abde
req 0 1 0a 8c39b 0 2 1c329b
rd fff00 fff00
req 1 2 41 5642a 1 4 06452a
req 0 3 0e 39d46 0 7 19dc46
rd 00100 40000
rd 5a6b7 95ab7
req 1 0 ff e1088 1 1 110b88
idle
req 0 1 08 7e53c 0 2 0e5d3c
rd 87954 68754
req 1 2 0b a2fd1 1 4 12fad1
rd 3c2e1 83ce1
req 0 3 00 04400 0 6 044000
rd 96d0f 7960f
idle
idle
idle

// File: project.f
+incdir+rtl
rtl/dram_geom_pkg.sv
rtl/vcache_dma_pkg.sv
rtl/dma_channel_map.sv
rtl/dram_addr_hash.sv
rtl/dram_req_merge.sv
rtl/manycore_dram_front.sv
tb/tb_manycore_dram_front.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

top=tb_manycore_dram_front

if ! verilator --binary --timing -f project.f --top-module "$top" -o "V$top"; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/V"$top")
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
